// ==== source/rvfi_pkg.sv ====
// RVFI retirement port types shared by the trace record hardware
// Import into any module that samples or forwards a retirement

package rvfi_pkg;

  localparam int unsigned XLEN = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned BYTE_MASK_W = XLEN / 8;

  // Data, address or PC value
  typedef logic [XLEN-1:0] xlen_t;

  // Instruction word, compressed encodings sit in the low half
  typedef logic [31:0] insn_t;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [BYTE_MASK_W-1:0] byte_mask_t;

  // One retirement as seen on the RVFI port
  typedef struct packed {
    logic       valid;
    insn_t      insn;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xlen_t      rs1_rdata;
    xlen_t      rs2_rdata;
    reg_addr_t  rd_addr;
    xlen_t      rd_wdata;
    xlen_t      pc_rdata;
    xlen_t      pc_wdata;
    xlen_t      mem_addr;
    byte_mask_t mem_rmask;
    byte_mask_t mem_wmask;
    xlen_t      mem_rdata;
    xlen_t      mem_wdata;
  } rvfi_retire_t;

endpackage

// ==== source/trace_pkg.sv ====
// Trace output definitions: instruction classes, access mask bits,
// opcode encodings and the packed trace record
// Import next to rvfi_pkg wherever records are built or decoded

package trace_pkg;

  import rvfi_pkg::*;

  // Instruction format classes, one per operand and immediate layout
  typedef enum logic [4:0] {
    CLS_NONE,
    CLS_R,
    CLS_I,
    CLS_I_SHIFT,
    CLS_JALR,
    CLS_U,
    CLS_J,
    CLS_B,
    CLS_CSR_REG,
    CLS_CSR_IMM,
    CLS_LOAD,
    CLS_STORE,
    CLS_FENCE,
    CLS_C_JR,
    CLS_C_JALR,
    CLS_C_ADD,
    CLS_C_LI,
    CLS_C_ADDI,
    CLS_C_ADDI16SP,
    CLS_C_LUI,
    CLS_C_SHIFT,
    CLS_C_ADDI4SPN,
    CLS_C_ANDI,
    CLS_C_BRANCH,
    CLS_C_ARITH,
    CLS_C_JAL,
    CLS_C_J,
    CLS_C_LOAD,
    CLS_C_STORE,
    CLS_INVALID
  } insn_class_e;

  // Data items touched by one instruction
  typedef logic [3:0] access_mask_t;

  localparam int unsigned ACC_RS1 = 0;
  localparam int unsigned ACC_RS2 = 1;
  localparam int unsigned ACC_RD  = 2;
  localparam int unsigned ACC_MEM = 3;

  // Compressed quadrants
  localparam logic [1:0] OPCODE_C0 = 2'b00;
  localparam logic [1:0] OPCODE_C1 = 2'b01;
  localparam logic [1:0] OPCODE_C2 = 2'b10;

  // Major opcodes of the 32-bit encodings
  localparam logic [6:0] OPC_LUI      = 7'h37;
  localparam logic [6:0] OPC_AUIPC    = 7'h17;
  localparam logic [6:0] OPC_JAL      = 7'h6f;
  localparam logic [6:0] OPC_JALR     = 7'h67;
  localparam logic [6:0] OPC_BRANCH   = 7'h63;
  localparam logic [6:0] OPC_LOAD     = 7'h03;
  localparam logic [6:0] OPC_STORE    = 7'h23;
  localparam logic [6:0] OPC_OPIMM    = 7'h13;
  localparam logic [6:0] OPC_OP       = 7'h33;
  localparam logic [6:0] OPC_SYSTEM   = 7'h73;
  localparam logic [6:0] OPC_MISC_MEM = 7'h0f;

  // One emitted trace record
  // Operand fields are zero when the matching access bit is clear
  typedef struct packed {
    xlen_t        pc;
    insn_t        insn;
    logic         compressed;
    insn_class_e  cls;
    access_mask_t access;
    reg_addr_t    rs1_addr;
    xlen_t        rs1_val;
    reg_addr_t    rs2_addr;
    xlen_t        rs2_val;
    reg_addr_t    rd_addr;
    xlen_t        rd_val;
    xlen_t        mem_addr;
    logic         mem_load;
    logic         mem_store;
    // Immediate, shift amount or jump target depending on cls
    xlen_t        imm;
  } trace_record_t;

endpackage

// ==== source/insn_classifier.sv ====
// Combinational decoder from an instruction word to its format class,
// compressed flag and the mask of registers and memory it touches

`timescale 1ns/100ps

module insn_classifier
  import rvfi_pkg::*;
  import trace_pkg::*;
(
  input  insn_t        insn,
  output insn_class_e  cls,
  output logic         compressed,
  output access_mask_t access
);

  // Operand-free SYSTEM words
  localparam insn_t InsnEcall  = 32'h0000_0073;
  localparam insn_t InsnEbreak = 32'h0010_0073;
  localparam insn_t InsnMret   = 32'h3020_0073;
  localparam insn_t InsnDret   = 32'h7b20_0073;
  localparam insn_t InsnWfi    = 32'h1050_0073;

  logic [1:0] quadrant;
  logic [2:0] c_funct3;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign quadrant   = insn[1:0];
  assign c_funct3   = insn[15:13];
  assign opcode     = insn[6:0];
  assign funct3     = insn[14:12];
  assign funct7     = insn[31:25];
  assign compressed = (quadrant != 2'b11);

  always_comb begin
    cls = CLS_INVALID;
    if (compressed) begin
      unique case (quadrant)
        OPCODE_C0: begin
          unique case (c_funct3)
            3'b000:  cls = (insn[12:2] == 11'h0) ? CLS_NONE : CLS_C_ADDI4SPN;
            3'b010:  cls = CLS_C_LOAD;
            3'b110:  cls = CLS_C_STORE;
            default: cls = CLS_INVALID;
          endcase
        end
        OPCODE_C1: begin
          unique case (c_funct3)
            3'b000: cls = CLS_C_ADDI;
            3'b001: cls = CLS_C_JAL;
            3'b010: cls = CLS_C_LI;
            // addi16sp and lui share funct3, split on rd
            3'b011: cls = (insn[11:7] == 5'd2) ? CLS_C_ADDI16SP : CLS_C_LUI;
            3'b100: begin
              unique case (insn[11:10])
                2'b00, 2'b01: cls = CLS_C_SHIFT;
                2'b10:        cls = CLS_C_ANDI;
                default:      cls = insn[12] ? CLS_INVALID : CLS_C_ARITH;
              endcase
            end
            3'b101:  cls = CLS_C_J;
            default: cls = CLS_C_BRANCH;
          endcase
        end
        default: begin
          unique case (c_funct3)
            3'b000: cls = CLS_C_SHIFT;
            3'b010: cls = CLS_C_LOAD;
            // c.mv, c.add, c.jr, c.jalr and c.ebreak
            3'b100: begin
              if (insn[12]) begin
                if (insn[11:2] == 10'h0) begin
                  cls = CLS_NONE;
                end else if (insn[6:2] == 5'd0) begin
                  cls = CLS_C_JALR;
                end else begin
                  cls = CLS_C_ADD;
                end
              end else begin
                cls = (insn[6:2] == 5'd0) ? CLS_C_JR : CLS_C_ADD;
              end
            end
            3'b110:  cls = CLS_C_STORE;
            default: cls = CLS_INVALID;
          endcase
        end
      endcase
    end else begin
      unique case (opcode)
        OPC_LUI, OPC_AUIPC: cls = CLS_U;
        OPC_JAL:            cls = CLS_J;
        OPC_JALR:           cls = (funct3 == 3'b000) ? CLS_JALR : CLS_INVALID;
        OPC_BRANCH:         cls = (funct3[2:1] == 2'b01) ? CLS_INVALID : CLS_B;
        OPC_OPIMM: begin
          if (funct3 == 3'b001) begin
            cls = (funct7 == 7'h00) ? CLS_I_SHIFT : CLS_INVALID;
          end else if (funct3 == 3'b101) begin
            cls = (funct7 == 7'h00 || funct7 == 7'h20) ? CLS_I_SHIFT : CLS_INVALID;
          end else begin
            cls = CLS_I;
          end
        end
        OPC_OP: begin
          // Base ALU ops, sub/sra, and RV32M on funct7 = 1
          if (funct7 == 7'h00 || funct7 == 7'h01) begin
            cls = CLS_R;
          end else if (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
            cls = CLS_R;
          end else begin
            cls = CLS_INVALID;
          end
        end
        OPC_SYSTEM: begin
          if (funct3 == 3'b000) begin
            if (insn == InsnEcall || insn == InsnEbreak || insn == InsnMret ||
                insn == InsnDret || insn == InsnWfi) begin
              cls = CLS_NONE;
            end else begin
              cls = CLS_INVALID;
            end
          end else if (funct3 == 3'b100) begin
            cls = CLS_INVALID;
          end else begin
            cls = funct3[2] ? CLS_CSR_IMM : CLS_CSR_REG;
          end
        end
        OPC_LOAD: begin
          unique case (funct3)
            3'b011, 3'b110, 3'b111: cls = CLS_INVALID;
            default:                cls = CLS_LOAD;
          endcase
        end
        OPC_STORE: cls = (funct3 < 3'd3) ? CLS_STORE : CLS_INVALID;
        OPC_MISC_MEM: begin
          unique case (funct3)
            3'b000:  cls = CLS_FENCE;
            // fence.i carries no operands
            3'b001:  cls = CLS_NONE;
            default: cls = CLS_INVALID;
          endcase
        end
        default: cls = CLS_INVALID;
      endcase
    end
  end

  always_comb begin
    access = '0;
    unique case (cls)
      CLS_R, CLS_B, CLS_C_ADD, CLS_C_ARITH: begin
        access[ACC_RS1] = 1'b1;
        access[ACC_RS2] = 1'b1;
        access[ACC_RD]  = 1'b1;
      end
      CLS_I, CLS_I_SHIFT, CLS_JALR, CLS_CSR_REG, CLS_C_ADDI, CLS_C_ADDI16SP,
      CLS_C_SHIFT, CLS_C_ANDI, CLS_C_JALR: begin
        access[ACC_RS1] = 1'b1;
        access[ACC_RD]  = 1'b1;
      end
      CLS_U, CLS_J, CLS_CSR_IMM, CLS_C_LI, CLS_C_LUI, CLS_C_ADDI4SPN, CLS_C_JAL: begin
        access[ACC_RD] = 1'b1;
      end
      CLS_C_JR, CLS_C_BRANCH: begin
        access[ACC_RS1] = 1'b1;
      end
      CLS_LOAD, CLS_C_LOAD: begin
        access[ACC_RS1] = 1'b1;
        access[ACC_RD]  = 1'b1;
        access[ACC_MEM] = 1'b1;
      end
      CLS_STORE, CLS_C_STORE: begin
        access[ACC_RS1] = 1'b1;
        access[ACC_RS2] = 1'b1;
        access[ACC_MEM] = 1'b1;
      end
      // NONE, FENCE, C_J and INVALID touch nothing
      default: access = '0;
    endcase
  end

endmodule

// ==== source/imm_extractor.sv ====
// Combinational immediate, shift amount and jump target extraction
// Selects the layout from the class given by insn_classifier

`timescale 1ns/100ps

module imm_extractor
  import rvfi_pkg::*;
  import trace_pkg::*;
(
  input  insn_t       insn,
  input  xlen_t       pc,
  input  xlen_t       pc_next,
  input  insn_class_e cls,
  output xlen_t       imm
);

  xlen_t i_imm;
  xlen_t s_imm;
  xlen_t b_off;
  xlen_t ci_imm;
  xlen_t cb_off;
  xlen_t addi16sp_imm;
  xlen_t addi4spn_imm;
  xlen_t cl_imm;
  xlen_t lwsp_imm;
  xlen_t swsp_imm;

  assign i_imm = {{20{insn[31]}}, insn[31:20]};
  assign s_imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign b_off = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  // Six-bit signed field shared by c.li, c.addi and c.andi
  assign ci_imm = {{26{insn[12]}}, insn[12], insn[6:2]};

  assign cb_off = {{23{insn[12]}}, insn[12], insn[6:5], insn[2], insn[11:10],
                   insn[4:3], 1'b0};
  assign addi16sp_imm = {{22{insn[12]}}, insn[12], insn[4:3], insn[5], insn[2],
                         insn[6], 4'b0};
  assign addi4spn_imm = {22'b0, insn[10:7], insn[12:11], insn[5], insn[6], 2'b00};

  // Word offsets of c.lw/c.sw and the stack-relative forms
  assign cl_imm   = {25'b0, insn[5], insn[12:10], insn[6], 2'b00};
  assign lwsp_imm = {24'b0, insn[3:2], insn[12], insn[6:4], 2'b00};
  assign swsp_imm = {24'b0, insn[8:7], insn[12:9], 2'b00};

  always_comb begin
    unique case (cls)
      CLS_I, CLS_JALR, CLS_LOAD: imm = i_imm;
      CLS_STORE:                 imm = s_imm;
      CLS_U:                     imm = {12'b0, insn[31:12]};
      CLS_I_SHIFT:               imm = {27'b0, insn[24:20]};
      // Branch target from the current pc, the next pc is the taken or not-taken path
      CLS_B:                     imm = pc + b_off;
      CLS_J, CLS_C_JAL, CLS_C_J: imm = pc_next;
      CLS_CSR_REG:               imm = {20'b0, insn[31:20]};
      CLS_CSR_IMM:               imm = {15'b0, insn[19:15], insn[31:20]};
      CLS_C_LI, CLS_C_ADDI,
      CLS_C_ANDI:                imm = ci_imm;
      CLS_C_ADDI16SP:            imm = addi16sp_imm;
      // Upper immediate as a 20-bit sign-extended field
      CLS_C_LUI:                 imm = {12'b0, {14{insn[12]}}, insn[12], insn[6:2]};
      CLS_C_SHIFT:               imm = {26'b0, insn[12], insn[6:2]};
      CLS_C_ADDI4SPN:            imm = addi4spn_imm;
      CLS_C_BRANCH:              imm = pc + cb_off;
      CLS_C_LOAD:                imm = (insn[1:0] == OPCODE_C0) ? cl_imm : lwsp_imm;
      CLS_C_STORE:               imm = (insn[1:0] == OPCODE_C0) ? cl_imm : swsp_imm;
      default:                   imm = '0;
    endcase
  end

endmodule

// ==== source/trace_record_builder.sv ====
// Cycle counter and output register of the trace path
// Masks operand values by the access mask and stamps each record
// with the counter value seen at the sampling edge

`timescale 1ns/100ps

module trace_record_builder
  import rvfi_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned CycleWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  setback_i,
  input  logic                  trace_enable_i,
  input  rvfi_retire_t          retire,
  input  insn_class_e           cls,
  input  logic                  compressed,
  input  access_mask_t          access,
  input  xlen_t                 imm,
  output logic                  record_valid_o,
  output trace_record_t         record_o,
  output logic [CycleWidth-1:0] cycle_o
);

  logic [CycleWidth-1:0] cycle_q;
  logic                  capture;
  trace_record_t         record_d;

  assign capture = retire.valid & trace_enable_i;

  // Free-running, wraps at 2^CycleWidth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else if (setback_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_comb begin
    record_d            = '0;
    record_d.pc         = retire.pc_rdata;
    record_d.insn       = compressed ? {16'b0, retire.insn[15:0]} : retire.insn;
    record_d.compressed = compressed;
    record_d.cls        = cls;
    record_d.access     = access;
    record_d.imm        = imm;
    if (access[ACC_RS1]) begin
      record_d.rs1_addr = retire.rs1_addr;
      record_d.rs1_val  = retire.rs1_rdata;
    end
    if (access[ACC_RS2]) begin
      record_d.rs2_addr = retire.rs2_addr;
      record_d.rs2_val  = retire.rs2_rdata;
    end
    if (access[ACC_RD]) begin
      record_d.rd_addr = retire.rd_addr;
      record_d.rd_val  = retire.rd_wdata;
    end
    if (access[ACC_MEM]) begin
      record_d.mem_addr  = retire.mem_addr;
      record_d.mem_load  = (retire.mem_rmask != '0);
      record_d.mem_store = (retire.mem_wmask != '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      record_valid_o <= 1'b0;
      record_o       <= '0;
      cycle_o        <= '0;
    end else begin
      record_valid_o <= capture;
      // Hold the last record between retirements
      if (capture) begin
        record_o <= record_d;
        cycle_o  <= cycle_q;
      end
    end
  end

endmodule

// ==== source/rvfi_trace_top.sv ====
// Trace record top level: decodes each RVFI retirement and emits one
// cycle-stamped record on the following clock

`timescale 1ns/100ps

module rvfi_trace_top
  import rvfi_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned CycleWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  setback_i,
  input  logic                  trace_enable_i,
  input  rvfi_retire_t          retire,
  output logic                  record_valid_o,
  output trace_record_t         record_o,
  output logic [CycleWidth-1:0] cycle_o
);

  insn_class_e  cls;
  logic         compressed;
  access_mask_t access;
  xlen_t        imm;

  insn_classifier insn_classifier_i (
    .insn       (retire.insn),
    .cls        (cls),
    .compressed (compressed),
    .access     (access)
  );

  imm_extractor imm_extractor_i (
    .insn    (retire.insn),
    .pc      (retire.pc_rdata),
    .pc_next (retire.pc_wdata),
    .cls     (cls),
    .imm     (imm)
  );

  trace_record_builder #(
    .CycleWidth (CycleWidth)
  ) trace_record_builder_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .setback_i      (setback_i),
    .trace_enable_i (trace_enable_i),
    .retire         (retire),
    .cls            (cls),
    .compressed     (compressed),
    .access         (access),
    .imm            (imm),
    .record_valid_o (record_valid_o),
    .record_o       (record_o),
    .cycle_o        (cycle_o)
  );

endmodule

// ==== bench/rvfi_trace_properties.sv ====
// Concurrent checks of the trace record top level, bound to rvfi_trace_top
// Expected records come from the RVFI inputs seen one edge earlier

`timescale 1ns/100ps

module rvfi_trace_properties
  import rvfi_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned CycleWidth = 32
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  setback_i,
  input logic                  trace_enable_i,
  input rvfi_retire_t          retire,
  input logic                  record_valid_o,
  input trace_record_t         record_o,
  input logic [CycleWidth-1:0] cycle_o
);

  // Expectation for the record that follows the current edge
  typedef struct packed {
    logic          capture;
    logic          after_setback;
    logic          imm_known;
    trace_record_t rec;
  } expect_t;

  insn_t                 word;
  expect_t               exp_d;
  expect_t               exp_q;
  logic                  setback_q;
  logic                  valid_q;
  logic [CycleWidth-1:0] cycle_q;
  int unsigned           failures = 0;

  assign word = retire.insn;

  // Reference decode of the stimulus table encodings
  // c.add entries always carry a nonzero rs2
  function automatic insn_class_e expected_class(insn_t w);
    insn_class_e c;
    casez (w)
      32'b0000000_?????_?????_000_?????_0110011:      c = CLS_R;
      32'b????_????_????_?????_000_?????_0010011:     c = CLS_I;
      32'b0000000_?????_?????_001_?????_0010011:      c = CLS_I_SHIFT;
      32'b????_????_????_????_????_?????_0110111:     c = CLS_U;
      32'b????_????_????_????_????_?????_1101111:     c = CLS_J;
      32'b???????_?????_?????_000_?????_1100011:      c = CLS_B;
      32'b????_????_????_?????_010_?????_0000011:     c = CLS_LOAD;
      32'b???????_?????_?????_010_?????_0100011:      c = CLS_STORE;
      32'h0000_0073:                                  c = CLS_NONE;
      32'b????_????_????_?????_001_?????_1110011:     c = CLS_CSR_REG;
      32'b????_????_????_?????_101_?????_1110011:     c = CLS_CSR_IMM;
      32'b????_????_????_????_100_0_?????_00000_10:   c = CLS_C_JR;
      32'b????_????_????_????_100_1_?????_?????_10:   c = CLS_C_ADD;
      32'b????_????_????_????_010_????_????_???_00:   c = CLS_C_LOAD;
      32'b????_????_????_????_110_????_????_???_01:   c = CLS_C_BRANCH;
      32'b????_????_????_????_010_????_????_???_01:   c = CLS_C_LI;
      default:                                        c = CLS_INVALID;
    endcase
    return c;
  endfunction

  // Bit order mem, rd, rs2, rs1
  function automatic access_mask_t expected_access(insn_class_e c);
    case (c)
      CLS_R, CLS_B, CLS_C_ADD:              return 4'b0111;
      CLS_I, CLS_I_SHIFT, CLS_CSR_REG:      return 4'b0101;
      CLS_U, CLS_J, CLS_CSR_IMM, CLS_C_LI:  return 4'b0100;
      CLS_C_JR, CLS_C_BRANCH:               return 4'b0001;
      CLS_LOAD, CLS_C_LOAD:                 return 4'b1101;
      CLS_STORE:                            return 4'b1011;
      default:                              return 4'b0000;
    endcase
  endfunction

  function automatic trace_record_t without_imm(trace_record_t r);
    r.imm = '0;
    return r;
  endfunction

  always_comb begin
    exp_d                = '0;
    exp_d.capture        = retire.valid & trace_enable_i;
    exp_d.after_setback  = setback_q;
    exp_d.rec.pc         = retire.pc_rdata;
    exp_d.rec.compressed = (word[1:0] != 2'b11);
    exp_d.rec.insn       = exp_d.rec.compressed ? {16'h0, word[15:0]} : word;
    exp_d.rec.cls        = expected_class(word);
    exp_d.rec.access     = expected_access(exp_d.rec.cls);
    if (exp_d.rec.access[ACC_RS1]) begin
      exp_d.rec.rs1_addr = retire.rs1_addr;
      exp_d.rec.rs1_val  = retire.rs1_rdata;
    end
    if (exp_d.rec.access[ACC_RS2]) begin
      exp_d.rec.rs2_addr = retire.rs2_addr;
      exp_d.rec.rs2_val  = retire.rs2_rdata;
    end
    if (exp_d.rec.access[ACC_RD]) begin
      exp_d.rec.rd_addr = retire.rd_addr;
      exp_d.rec.rd_val  = retire.rd_wdata;
    end
    if (exp_d.rec.access[ACC_MEM]) begin
      exp_d.rec.mem_addr  = retire.mem_addr;
      exp_d.rec.mem_load  = |retire.mem_rmask;
      exp_d.rec.mem_store = |retire.mem_wmask;
    end
    // Immediates of addi, lw, beq, c.beqz and jal
    exp_d.imm_known = 1'b1;
    case (exp_d.rec.cls)
      CLS_I, CLS_LOAD: exp_d.rec.imm = {{20{word[31]}}, word[31:20]};
      CLS_B: begin
        exp_d.rec.imm = retire.pc_rdata +
                        {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      end
      CLS_C_BRANCH: begin
        exp_d.rec.imm = retire.pc_rdata + {{23{word[12]}}, word[12], word[6:5], word[2],
                                           word[11:10], word[4:3], 1'b0};
      end
      CLS_J:   exp_d.rec.imm = retire.pc_wdata;
      default: exp_d.imm_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_q     <= '0;
      setback_q <= 1'b0;
      valid_q   <= 1'b0;
      cycle_q   <= '0;
    end else begin
      exp_q     <= exp_d;
      setback_q <= setback_i;
      valid_q   <= record_valid_o;
      cycle_q   <= cycle_o;
    end
  end

  assert property (@(posedge clk_i) !rst_ni |-> !record_valid_o && record_o == '0)
    else begin
      $error("mismatch at %0t: record_valid_o/record_o got %b/%h expected 0/0", $time,
             $sampled(record_valid_o), $sampled(record_o));
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) record_valid_o == exp_q.capture)
    else begin
      $error("mismatch at %0t: record_valid_o got %b expected %b", $time,
             $sampled(record_valid_o), $sampled(exp_q.capture));
      failures++;
    end

  // Records on adjacent cycles without a setback in between
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    record_valid_o && valid_q && !exp_q.after_setback |-> cycle_o == cycle_q + 1'b1)
    else begin
      $error("mismatch at %0t: cycle_o got %0d expected %0d", $time,
             $sampled(cycle_o), $sampled(cycle_q) + 1'b1);
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    record_valid_o && exp_q.after_setback |-> cycle_o == '0)
    else begin
      $error("mismatch at %0t: cycle_o got %0d expected 0", $time, $sampled(cycle_o));
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    record_valid_o |-> without_imm(record_o) == without_imm(exp_q.rec))
    else begin
      $error("mismatch at %0t: record_o got %h expected %h", $time,
             without_imm($sampled(record_o)), without_imm($sampled(exp_q.rec)));
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    record_valid_o && exp_q.imm_known |-> record_o.imm == exp_q.rec.imm)
    else begin
      $error("mismatch at %0t: record_o.imm got %h expected %h", $time,
             $sampled(record_o.imm), $sampled(exp_q.rec.imm));
      failures++;
    end

endmodule

bind rvfi_trace_top rvfi_trace_properties #(
  .CycleWidth (CycleWidth)
) rvfi_trace_properties_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .setback_i      (setback_i),
  .trace_enable_i (trace_enable_i),
  .retire         (retire),
  .record_valid_o (record_valid_o),
  .record_o       (record_o),
  .cycle_o        (cycle_o)
);

// ==== bench/tb_rvfi_trace.sv ====
// Testbench for the RVFI trace record top level
// Drives retirements drawn by an LCG from a table of encodings
// Record checking lives in the bound rvfi_trace_properties module

`timescale 1ns/100ps

module tb_rvfi_trace
  import rvfi_pkg::*;
  import trace_pkg::*;
();

  localparam int unsigned CycleWidth    = 32;
  localparam int unsigned NumEntries    = 17;
  localparam int unsigned TimeoutCycles = 8;

  // add addi slli lui jal beq lw sw csrrw csrrwi ecall
  // c.jr c.add c.lw c.beqz c.li and an unknown opcode
  localparam insn_t InsnBase [NumEntries] = '{
    32'h0000_0033, 32'h0000_0013, 32'h0000_1013, 32'h0000_0037, 32'h0000_006f,
    32'h0000_0063, 32'h0000_2003, 32'h0000_2023, 32'h0000_1073, 32'h0000_5073,
    32'h0000_0073, 32'h0000_8002, 32'h0000_9006, 32'h0000_4000, 32'h0000_c001,
    32'h0000_4001, 32'h0000_007f
  };
  // Bits randomized around each base, upper half too for compressed words
  localparam insn_t InsnFields [NumEntries] = '{
    32'h01ff_8f80, 32'hffff_8f80, 32'h01ff_8f80, 32'hffff_ff80, 32'hffff_ff80,
    32'hffff_8f80, 32'hffff_8f80, 32'hffff_8f80, 32'hffff_8f80, 32'hffff_8f80,
    32'h0000_0000, 32'hffff_0f80, 32'hffff_0ff8, 32'hffff_1ffc, 32'hffff_1ffc,
    32'hffff_1ffc, 32'hffff_ff80
  };

  logic                  clk_i          = 1'b0;
  logic                  rst_ni         = 1'b1;
  logic                  setback_i      = 1'b0;
  logic                  trace_enable_i = 1'b0;
  rvfi_retire_t          retire         = '0;
  logic                  record_valid_o;
  trace_record_t         record_o;
  logic [CycleWidth-1:0] cycle_o;

  logic [31:0] lcg_state = 32'h3f48;
  int unsigned tb_errors = 0;
  int unsigned driven = 0;
  int unsigned tests = 0;
  int unsigned failures_at_start = 0;

  always #2 clk_i = ~clk_i;

  rvfi_trace_top #(
    .CycleWidth (CycleWidth)
  ) rvfi_trace_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .setback_i      (setback_i),
    .trace_enable_i (trace_enable_i),
    .retire         (retire),
    .record_valid_o (record_valid_o),
    .record_o       (record_o),
    .cycle_o        (cycle_o)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Folds the high half down, the low LCG bits repeat quickly
  task automatic draw(output logic [31:0] value);
    lcg_state = lcg_step(lcg_state);
    value = lcg_state ^ (lcg_state >> 15);
  endtask

  function automatic int unsigned total_failures();
    return tb_errors + rvfi_trace_top_i.rvfi_trace_properties_i.failures;
  endfunction

  task automatic make_retirement(input int unsigned entry, output rvfi_retire_t r);
    logic [31:0] v;
    r = '0;
    r.valid = 1'b1;
    draw(v);
    r.insn = InsnBase[entry] | (v & InsnFields[entry]);
    draw(v);
    r.rs1_addr  = v[4:0];
    r.rs2_addr  = v[9:5];
    r.rd_addr   = v[14:10];
    r.mem_rmask = v[19:16];
    r.mem_wmask = v[23:20];
    draw(v);
    r.rs1_rdata = v;
    draw(v);
    r.rs2_rdata = v;
    draw(v);
    r.rd_wdata = v;
    draw(v);
    r.pc_rdata = {v[31:1], 1'b0};
    draw(v);
    r.pc_wdata = {v[31:1], 1'b0};
    draw(v);
    r.mem_addr = v;
    draw(v);
    r.mem_rdata = v;
    draw(v);
    r.mem_wdata = v;
  endtask

  // Waits for the next record, gives up after TimeoutCycles
  task automatic wait_record(output bit seen);
    seen = 1'b0;
    for (int unsigned c = 0; c < TimeoutCycles && !seen; c++) begin
      @(negedge clk_i);
      seen = record_valid_o;
    end
  endtask

  task automatic sweep_table();
    rvfi_retire_t r;
    bit           seen;
    for (int unsigned e = 0; e < NumEntries; e++) begin
      make_retirement(e, r);
      @(posedge clk_i);
      retire <= r;
      driven++;
      @(posedge clk_i);
      retire <= '0;
      wait_record(seen);
      if (!seen) begin
        $display("no record appeared for table entry %0d", e);
        tb_errors++;
      end
    end
  endtask

  // Back-to-back retirements with an occasional idle slot and setback pulse
  task automatic run_random(input int unsigned count, input bit use_setback);
    rvfi_retire_t r;
    logic [31:0]  v;
    for (int unsigned i = 0; i < count; i++) begin
      draw(v);
      make_retirement(v[31:16] % NumEntries, r);
      r.valid = (v[2:0] != 3'd0);
      @(posedge clk_i);
      retire    <= r;
      setback_i <= use_setback && (v[6:3] == 4'd0);
      driven += r.valid;
    end
    @(posedge clk_i);
    retire    <= '0;
    setback_i <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    repeat (3) @(posedge clk_i);
    tests++;
    $display("test %s finished with %0d failures", name,
             total_failures() - failures_at_start);
    failures_at_start = total_failures();
  endtask

  initial begin
    #1;
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni         <= 1'b1;
    trace_enable_i <= 1'b1;

    sweep_table();
    finish_test("table_sweep");

    run_random(300, 1'b0);
    finish_test("back_to_back");

    @(posedge clk_i);
    trace_enable_i <= 1'b0;
    run_random(40, 1'b0);
    @(posedge clk_i);
    trace_enable_i <= 1'b1;
    finish_test("trace_disabled");

    run_random(300, 1'b1);
    finish_test("setback");

    $display("%0d tests, %0d retirements driven, %0d failures", tests, driven,
             total_failures());
    if (total_failures() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/rvfi_pkg.sv
source/trace_pkg.sv
source/insn_classifier.sv
source/imm_extractor.sv
source/trace_record_builder.sv
source/rvfi_trace_top.sv
bench/rvfi_trace_properties.sv
bench/tb_rvfi_trace.sv
